// File: source/sd_cmd_pkg.sv
package sd_cmd_pkg;

    // Register port
    localparam int REG_ADDR_W = 8;
    localparam int REG_DATA_W = 32;

    localparam logic [REG_ADDR_W-1:0] ADDR_ARGUMENT   = 8'h00;
    localparam logic [REG_ADDR_W-1:0] ADDR_COMMAND    = 8'h04;
    localparam logic [REG_ADDR_W-1:0] ADDR_RESPONSE   = 8'h08;
    localparam logic [REG_ADDR_W-1:0] ADDR_INT_STATUS = 8'h0C;
    localparam logic [REG_ADDR_W-1:0] ADDR_INT_ENABLE = 8'h10;
    localparam logic [REG_ADDR_W-1:0] ADDR_CLOCK_DIV  = 8'h14;
    localparam logic [REG_ADDR_W-1:0] ADDR_SOFT_RESET = 8'h18;
    localparam logic [REG_ADDR_W-1:0] ADDR_PRESENT    = 8'h1C;

    // Command frame layout
    localparam int CMD_INDEX_W  = 6;
    localparam int CMD_ARG_W    = 32;
    localparam int CMD_FRAME_W  = 48;
    localparam int CRC7_W       = 7;
    localparam int CMD_RESP_BIT = 8;
    localparam int CMD_BODY_W   = CMD_FRAME_W - CRC7_W - 1;
    localparam int RESP_BODY_W  = CMD_INDEX_W + CMD_ARG_W;
    localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09;

    localparam int DIV_W             = 8;
    localparam int RESP_TIMEOUT_CLKS = 64;
    localparam int BIT_CNT_W         = $clog2(CMD_FRAME_W + 1);
    localparam int TMO_CNT_W         = $clog2(RESP_TIMEOUT_CLKS);

    // Interrupt bits
    localparam int INT_CMD_DONE  = 0;
    localparam int INT_CRC_ERR   = 1;
    localparam int INT_INDEX_ERR = 2;
    localparam int INT_TIMEOUT   = 3;
    localparam int INT_W         = 4;

    typedef enum logic {
        RESP_NONE  = 1'b0,
        RESP_SHORT = 1'b1
    } resp_type_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT,
        ST_RECV,
        ST_FINISH
    } serial_state_e;

endpackage

// File: source/sd_cmd_ifs.sv
interface sd_cmd_req_if;
    import sd_cmd_pkg::*;

    logic                   start;
    logic [CMD_INDEX_W-1:0] cmd_index;
    logic [CMD_ARG_W-1:0]   argument;
    resp_type_e             resp_type;
    logic                   busy;
    logic                   done;
    logic                   crc_err;
    logic                   index_err;
    logic                   timeout;
    logic [CMD_ARG_W-1:0]   response;

    modport regs (
        output start, cmd_index, argument, resp_type,
        input  busy, done, crc_err, index_err, timeout, response
    );

    modport master (
        input  start, cmd_index, argument, resp_type,
        output busy, done, crc_err, index_err, timeout, response
    );
endinterface

interface sd_cmd_frame_if;
    import sd_cmd_pkg::*;

    logic                   start;
    logic [CMD_BODY_W-1:0]  frame;
    logic                   expect_resp;
    logic                   finish;
    logic [RESP_BODY_W-1:0] resp_frame;
    logic                   crc_ok;
    logic                   timed_out;

    modport master (
        output start, frame, expect_resp,
        input  finish, resp_frame, crc_ok, timed_out
    );

    modport serial (
        input  start, frame, expect_resp,
        output finish, resp_frame, crc_ok, timed_out
    );
endinterface

// File: source/sd_host_regs.sv
module sd_host_regs (
    input  logic                              s00_axi_aclk,
    input  logic                              rst_n_i,
    input  logic                              reg_wr_i,
    input  logic                              reg_rd_i,
    input  logic [sd_cmd_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [sd_cmd_pkg::REG_DATA_W-1:0] reg_wdata_i,
    output logic [sd_cmd_pkg::REG_DATA_W-1:0] reg_rdata_o,
    sd_cmd_req_if.regs                        cmd,
    output logic [sd_cmd_pkg::DIV_W-1:0]      divisor_o,
    output logic                              cmd_soft_rst_o,
    output logic                              interrupt_o
);
    import sd_cmd_pkg::*;

    logic [INT_W-1:0]      int_status_q;
    logic [INT_W-1:0]      int_enable_q;
    logic [INT_W-1:0]      int_set;
    logic [INT_W-1:0]      int_clr;
    logic [REG_DATA_W-1:0] rdata_d;
    logic [CMD_ARG_W-1:0]  response_q;
    logic                  cmd_accept;

    // Drop a new command while one is in flight or just launched
    assign cmd_accept = reg_wr_i && (reg_addr_i == ADDR_COMMAND) && !cmd.busy && !cmd.start;

    always_comb begin
        int_set = '0;
        int_set[INT_CMD_DONE]  = cmd.done;
        int_set[INT_CRC_ERR]   = cmd.crc_err;
        int_set[INT_INDEX_ERR] = cmd.index_err;
        int_set[INT_TIMEOUT]   = cmd.timeout;
    end

    assign int_clr = (reg_wr_i && (reg_addr_i == ADDR_INT_STATUS)) ?
                     reg_wdata_i[INT_W-1:0] : '0;

    always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmd.start      <= 1'b0;
            cmd_soft_rst_o <= 1'b0;
            int_status_q   <= '0;
            int_enable_q   <= '0;
            divisor_o      <= '0;
        end else begin
            cmd.start      <= cmd_accept;
            cmd_soft_rst_o <= reg_wr_i && (reg_addr_i == ADDR_SOFT_RESET) && reg_wdata_i[0];
            // New events win over a clear in the same cycle
            int_status_q   <= (int_status_q & ~int_clr) | int_set;
            if (reg_wr_i && (reg_addr_i == ADDR_INT_ENABLE)) begin
                int_enable_q <= reg_wdata_i[INT_W-1:0];
            end
            if (reg_wr_i && (reg_addr_i == ADDR_CLOCK_DIV)) begin
                divisor_o <= reg_wdata_i[DIV_W-1:0];
            end
        end
    end

    always_ff @(posedge s00_axi_aclk) begin
        if (reg_wr_i && (reg_addr_i == ADDR_ARGUMENT)) begin
            cmd.argument <= reg_wdata_i;
        end
        if (cmd_accept) begin
            cmd.cmd_index <= reg_wdata_i[CMD_INDEX_W-1:0];
            cmd.resp_type <= resp_type_e'(reg_wdata_i[CMD_RESP_BIT]);
        end
        if (reg_rd_i) begin
            reg_rdata_o <= rdata_d;
        end
    end

    // Card status kept only from a clean response
    always_ff @(posedge s00_axi_aclk) begin
        if (cmd.done && !cmd.crc_err && !cmd.index_err && !cmd.timeout) begin
            response_q <= cmd.response;
        end
    end

    always_comb begin
        rdata_d = '0;
        case (reg_addr_i)
            ADDR_ARGUMENT:   rdata_d = cmd.argument;
            ADDR_COMMAND: begin
                rdata_d[CMD_INDEX_W-1:0] = cmd.cmd_index;
                rdata_d[CMD_RESP_BIT]    = cmd.resp_type;
            end
            ADDR_RESPONSE:   rdata_d = response_q;
            ADDR_INT_STATUS: rdata_d[INT_W-1:0] = int_status_q;
            ADDR_INT_ENABLE: rdata_d[INT_W-1:0] = int_enable_q;
            ADDR_CLOCK_DIV:  rdata_d[DIV_W-1:0] = divisor_o;
            ADDR_PRESENT:    rdata_d[0] = cmd.busy;
            default:         rdata_d = '0;
        endcase
    end

    assign interrupt_o = |(int_status_q & int_enable_q);

    // The master must never see a second launch during a command
    a_start_not_busy: assert property (
        @(posedge s00_axi_aclk) disable iff (!rst_n_i) cmd.start |-> !cmd.busy
    );

endmodule

// File: source/sd_clock_divider.sv
module sd_clock_divider (
    input  logic                         s00_axi_aclk,
    input  logic                         rst_n_i,
    input  logic [sd_cmd_pkg::DIV_W-1:0] divisor_i,
    output logic                         sd_clk_o,
    output logic                         sd_rise_tick_o,
    output logic                         sd_fall_tick_o
);
    import sd_cmd_pkg::*;

    logic [DIV_W-1:0] cnt_q;
    logic             wrap;

    // A smaller divisor written mid-count still wraps at once
    assign wrap = (cnt_q >= divisor_i);

    always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q          <= '0;
            sd_clk_o       <= 1'b0;
            sd_rise_tick_o <= 1'b0;
            sd_fall_tick_o <= 1'b0;
        end else begin
            // Ticks are high in the first cycle after the pin edge
            sd_rise_tick_o <= wrap && !sd_clk_o;
            sd_fall_tick_o <= wrap && sd_clk_o;
            if (wrap) begin
                cnt_q    <= '0;
                sd_clk_o <= ~sd_clk_o;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

// File: source/sd_cmd_master.sv
module sd_cmd_master (
    input  logic         s00_axi_aclk,
    input  logic         rst_n_i,
    input  logic         soft_rst_i,
    sd_cmd_req_if.master req,
    sd_cmd_frame_if.master ser
);
    import sd_cmd_pkg::*;

    logic                   index_bad;
    logic [CMD_INDEX_W-1:0] sent_index;
    logic [CMD_INDEX_W-1:0] resp_index;

    assign sent_index = ser.frame[CMD_ARG_W +: CMD_INDEX_W];
    assign resp_index = ser.resp_frame[CMD_ARG_W +: CMD_INDEX_W];
    assign index_bad  = (resp_index != sent_index);

    always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req.busy        <= 1'b0;
            req.done        <= 1'b0;
            req.crc_err     <= 1'b0;
            req.index_err   <= 1'b0;
            req.timeout     <= 1'b0;
            ser.start       <= 1'b0;
            ser.expect_resp <= 1'b0;
        end else if (soft_rst_i) begin
            req.busy      <= 1'b0;
            req.done      <= 1'b0;
            req.crc_err   <= 1'b0;
            req.index_err <= 1'b0;
            req.timeout   <= 1'b0;
            ser.start     <= 1'b0;
        end else begin
            ser.start     <= req.start;
            req.done      <= ser.finish;
            // Response checks only apply when the card was asked to answer
            req.timeout   <= ser.finish && ser.expect_resp && ser.timed_out;
            req.crc_err   <= ser.finish && ser.expect_resp && !ser.timed_out && !ser.crc_ok;
            req.index_err <= ser.finish && ser.expect_resp && !ser.timed_out && index_bad;
            if (req.start) begin
                req.busy        <= 1'b1;
                ser.expect_resp <= (req.resp_type == RESP_SHORT);
            end else if (ser.finish) begin
                req.busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge s00_axi_aclk) begin
        if (req.start) begin
            // Start bit 0, transmission bit 1
            ser.frame <= {1'b0, 1'b1, req.cmd_index, req.argument};
        end
        if (ser.finish) begin
            req.response <= ser.resp_frame[CMD_ARG_W-1:0];
        end
    end

endmodule

// File: source/sd_cmd_serial_host.sv
module sd_cmd_serial_host (
    input  logic           s00_axi_aclk,
    input  logic           rst_n_i,
    input  logic           soft_rst_i,
    input  logic           sd_rise_tick_i,
    input  logic           sd_fall_tick_i,
    sd_cmd_frame_if.serial ser,
    input  logic           sd_cmd_i,
    output logic           sd_cmd_o,
    output logic           sd_cmd_oe_o
);
    import sd_cmd_pkg::*;

    serial_state_e          state_q;
    logic [BIT_CNT_W-1:0]   bit_cnt_q;
    logic [TMO_CNT_W-1:0]   tmo_cnt_q;
    logic [CRC7_W-1:0]      crc_q;
    logic [RESP_BODY_W-1:0] rx_q;
    logic                   crc_bad_q;
    logic                   timed_out_q;
    logic                   tx_bit;

    // Serial CRC7, x^7 + x^3 + 1
    function automatic logic [CRC7_W-1:0] crc7_next(input logic [CRC7_W-1:0] crc,
                                                     input logic din);
        logic fb;
        fb = din ^ crc[CRC7_W-1];
        return {crc[CRC7_W-2:0], 1'b0} ^ (fb ? CRC7_POLY : '0);
    endfunction

    // Frame is held by the master for the whole command
    assign tx_bit = ser.frame[BIT_CNT_W'(CMD_BODY_W - 1) - bit_cnt_q];

    always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            bit_cnt_q   <= '0;
            tmo_cnt_q   <= '0;
            crc_q       <= '0;
            rx_q        <= '0;
            crc_bad_q   <= 1'b0;
            timed_out_q <= 1'b0;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
        end else if (soft_rst_i) begin
            state_q     <= ST_IDLE;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (ser.start) begin
                        state_q     <= ST_SEND;
                        bit_cnt_q   <= '0;
                        tmo_cnt_q   <= '0;
                        crc_q       <= '0;
                        crc_bad_q   <= 1'b0;
                        timed_out_q <= 1'b0;
                    end
                end
                ST_SEND: begin
                    if (sd_fall_tick_i) begin
                        if (bit_cnt_q < BIT_CNT_W'(CMD_BODY_W)) begin
                            sd_cmd_o    <= tx_bit;
                            sd_cmd_oe_o <= 1'b1;
                            crc_q       <= crc7_next(crc_q, tx_bit);
                            bit_cnt_q   <= bit_cnt_q + 1'b1;
                        end else if (bit_cnt_q < BIT_CNT_W'(CMD_FRAME_W - 1)) begin
                            sd_cmd_o  <= crc_q[CRC7_W-1];
                            crc_q     <= {crc_q[CRC7_W-2:0], 1'b0};
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end else if (bit_cnt_q == BIT_CNT_W'(CMD_FRAME_W - 1)) begin
                            // End bit
                            sd_cmd_o  <= 1'b1;
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end else begin
                            sd_cmd_oe_o <= 1'b0;
                            state_q     <= ser.expect_resp ? ST_WAIT : ST_FINISH;
                        end
                    end
                end
                ST_WAIT: begin
                    if (sd_rise_tick_i) begin
                        if (!sd_cmd_i) begin
                            // Start bit leaves a zero CRC unchanged
                            state_q   <= ST_RECV;
                            bit_cnt_q <= BIT_CNT_W'(1);
                            crc_q     <= '0;
                        end else if (tmo_cnt_q == TMO_CNT_W'(RESP_TIMEOUT_CLKS - 1)) begin
                            timed_out_q <= 1'b1;
                            state_q     <= ST_FINISH;
                        end else begin
                            tmo_cnt_q <= tmo_cnt_q + 1'b1;
                        end
                    end
                end
                ST_RECV: begin
                    if (sd_rise_tick_i) begin
                        if (bit_cnt_q < BIT_CNT_W'(CMD_BODY_W)) begin
                            // Transmission bit falls off the top
                            rx_q  <= {rx_q[RESP_BODY_W-2:0], sd_cmd_i};
                            crc_q <= crc7_next(crc_q, sd_cmd_i);
                        end else if (bit_cnt_q < BIT_CNT_W'(CMD_FRAME_W - 1)) begin
                            if (sd_cmd_i != crc_q[CRC7_W-1]) begin
                                crc_bad_q <= 1'b1;
                            end
                            crc_q <= {crc_q[CRC7_W-2:0], 1'b0};
                        end
                        if (bit_cnt_q == BIT_CNT_W'(CMD_FRAME_W - 1)) begin
                            state_q <= ST_FINISH;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                ST_FINISH: state_q <= ST_IDLE;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    assign ser.finish     = (state_q == ST_FINISH);
    assign ser.resp_frame = rx_q;
    assign ser.crc_ok     = !crc_bad_q;
    assign ser.timed_out  = timed_out_q;

    // Line stays released while the card owns it
    a_oe_released: assert property (
        @(posedge s00_axi_aclk) disable iff (!rst_n_i)
        (state_q inside {ST_WAIT, ST_RECV}) |-> !sd_cmd_oe_o
    );

endmodule

// File: source/sd_cmd_top.sv
module sd_cmd_top (
    input  logic                              s00_axi_aclk,
    input  logic                              rst_n_i,
    input  logic                              reg_wr_i,
    input  logic                              reg_rd_i,
    input  logic [sd_cmd_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [sd_cmd_pkg::REG_DATA_W-1:0] reg_wdata_i,
    output logic [sd_cmd_pkg::REG_DATA_W-1:0] reg_rdata_o,
    output logic                              sd_clk_o,
    input  logic                              sd_cmd_i,
    output logic                              sd_cmd_o,
    output logic                              sd_cmd_oe_o,
    output logic                              interrupt_o
);
    import sd_cmd_pkg::*;

    logic [DIV_W-1:0] divisor;
    logic             cmd_soft_rst;
    logic             sd_rise_tick;
    logic             sd_fall_tick;

    sd_cmd_req_if   req_if ();
    sd_cmd_frame_if frame_if ();

    sd_host_regs u_regs (
        .s00_axi_aclk   (s00_axi_aclk),
        .rst_n_i        (rst_n_i),
        .reg_wr_i       (reg_wr_i),
        .reg_rd_i       (reg_rd_i),
        .reg_addr_i     (reg_addr_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_rdata_o    (reg_rdata_o),
        .cmd            (req_if.regs),
        .divisor_o      (divisor),
        .cmd_soft_rst_o (cmd_soft_rst),
        .interrupt_o    (interrupt_o)
    );

    sd_clock_divider u_clk_div (
        .s00_axi_aclk   (s00_axi_aclk),
        .rst_n_i        (rst_n_i),
        .divisor_i      (divisor),
        .sd_clk_o       (sd_clk_o),
        .sd_rise_tick_o (sd_rise_tick),
        .sd_fall_tick_o (sd_fall_tick)
    );

    sd_cmd_master u_master (
        .s00_axi_aclk (s00_axi_aclk),
        .rst_n_i      (rst_n_i),
        .soft_rst_i   (cmd_soft_rst),
        .req          (req_if.master),
        .ser          (frame_if.master)
    );

    sd_cmd_serial_host u_serial (
        .s00_axi_aclk   (s00_axi_aclk),
        .rst_n_i        (rst_n_i),
        .soft_rst_i     (cmd_soft_rst),
        .sd_rise_tick_i (sd_rise_tick),
        .sd_fall_tick_i (sd_fall_tick),
        .ser            (frame_if.serial),
        .sd_cmd_i       (sd_cmd_i),
        .sd_cmd_o       (sd_cmd_o),
        .sd_cmd_oe_o    (sd_cmd_oe_o)
    );

endmodule

// File: tests/sd_card_model.sv
module sd_card_model (
    input  logic        sd_clk_i,
    input  logic        cmd_i,
    input  logic        cmd_oe_i,
    input  logic        resp_en_i,
    input  logic [47:0] resp_frame_i,
    output logic        cmd_o,
    output logic [47:0] frame_o,
    output int          frame_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [47:0] rx;

    // Two idle clocks of N_CR, then one bit per falling edge
    task automatic send_response(input logic [47:0] resp);
        repeat (2) @(negedge sd_clk_i);
        for (int i = 47; i >= 0; i--) begin
            @(negedge sd_clk_i);
            #1;
            cmd_o = resp[i];
        end
        @(negedge sd_clk_i);
        #1;
        cmd_o = 1'b1;
    endtask

    initial begin
        cmd_o       = 1'b1;
        frame_o     = '0;
        frame_cnt_o = 0;
        rx          = '0;
        forever begin
            // Host bits are stable around the falling SD clock edge
            @(negedge sd_clk_i);
            if (cmd_oe_i === 1'b1) begin
                // First driven bit ends up in bit 47 after the shifts
                rx = {47'b0, cmd_i};
                repeat (47) begin
                    @(negedge sd_clk_i);
                    rx = {rx[46:0], cmd_i};
                end
                frame_o     = rx;
                frame_cnt_o = frame_cnt_o + 1;
                if (resp_en_i) begin
                    send_response(resp_frame_i);
                end
            end
        end
    end

endmodule

// File: tests/tb_sd_cmd.sv
module tb_sd_cmd;
    timeunit 1ns;
    timeprecision 1ps;

    import sd_cmd_pkg::*;

    // Covers the slowest command, divisor 7 with a full response
    localparam int WAIT_LIMIT = 5000;

    logic        clk;
    logic        rst_n;
    logic        reg_wr;
    logic        reg_rd;
    logic [7:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        sd_clk;
    logic        card_cmd;
    logic        host_cmd;
    logic        host_oe;
    logic        interrupt;
    logic        resp_en;
    logic [47:0] resp_frame;
    logic [47:0] card_frame;
    int          frame_cnt;
    int          errors;
    int          checks;
    integer      seed;
    bit          stalled;
    string       tag;

    sd_cmd_top dut (
        .s00_axi_aclk (clk),
        .rst_n_i      (rst_n),
        .reg_wr_i     (reg_wr),
        .reg_rd_i     (reg_rd),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_rdata_o  (reg_rdata),
        .sd_clk_o     (sd_clk),
        .sd_cmd_i     (card_cmd),
        .sd_cmd_o     (host_cmd),
        .sd_cmd_oe_o  (host_oe),
        .interrupt_o  (interrupt)
    );

    sd_card_model card (
        .sd_clk_i     (sd_clk),
        .cmd_i        (host_cmd),
        .cmd_oe_i     (host_oe),
        .resp_en_i    (resp_en),
        .resp_frame_i (resp_frame),
        .cmd_o        (card_cmd),
        .frame_o      (card_frame),
        .frame_cnt_o  (frame_cnt)
    );

    always #2 clk = ~clk;

    // CRC7 of a 40-bit frame body, x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] body);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = body[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s %s, got 0x%0h, expected 0x%0h",
                     $time, tag, what, actual, expected);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_rd <= 1'b0;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic wait_for_rise(input bit watch_oe, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while ((watch_oe ? host_oe : interrupt) !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if ((watch_oe ? host_oe : interrupt) !== 1'b1) begin
            errors++;
            stalled = 1'b1;
            $display("%s timed out after %0d cycles waiting for %s", tag, WAIT_LIMIT, what);
        end
    endtask

    // Cycles between the second and third sd_clk edges
    task automatic measure_half_period(output int cycles);
        logic prev;
        int   edges;
        int   count;
        int   waited;
        edges  = 0;
        count  = 0;
        waited = 0;
        cycles = -1;
        @(negedge clk);
        prev = sd_clk;
        while (edges < 3 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            count++;
            if (sd_clk !== prev) begin
                edges++;
                prev   = sd_clk;
                cycles = count;
                count  = 0;
            end
        end
        if (edges < 3) begin
            errors++;
            stalled = 1'b1;
            $display("%s timed out waiting for sd_clk to toggle", tag);
        end
    endtask

    task automatic run_command(input logic [7:0] divisor, input logic [5:0] idx,
                               input logic [31:0] arg, input logic rtype,
                               input logic [31:0] status, input logic [1:0] fault,
                               input logic [3:0] exp_int);
        logic [5:0]  resp_idx;
        logic [6:0]  resp_crc;
        logic [31:0] rdata;
        int          frames_before;
        int          half;
        int          gap;
        tag = $sformatf("CMD%0d:", idx);
        gap = $unsigned($random(seed)) % 8 + 1;
        repeat (gap) @(posedge clk);
        write_reg(ADDR_CLOCK_DIV, {24'b0, divisor});
        measure_half_period(half);
        if (stalled) return;
        check_value(half, divisor + 1, "sd_clk half period");

        // Fault 1 breaks the CRC, 2 the index, 3 keeps the card silent
        resp_idx = (fault == 2'd2) ? idx ^ 6'h01 : idx;
        resp_crc = crc7_of({2'b00, resp_idx, status});
        if (fault == 2'd1) begin
            resp_crc = resp_crc ^ 7'h01;
        end
        @(posedge clk);
        resp_en    <= rtype && (fault != 2'd3);
        resp_frame <= {2'b00, resp_idx, status, resp_crc, 1'b1};
        frames_before = frame_cnt;
        write_reg(ADDR_ARGUMENT, arg);
        write_reg(ADDR_COMMAND, {23'b0, rtype, 2'b00, idx});
        wait_for_rise(1'b0, "the command interrupt");
        if (stalled) return;

        check_value(frame_cnt, frames_before + 1, "frames on the line");
        check_value(card_frame[47], 1'b0, "start bit");
        check_value(card_frame[46], 1'b1, "transmission bit");
        check_value(card_frame[45:40], idx, "index on the line");
        check_value(card_frame[39:8], arg, "argument on the line");
        check_value(card_frame[7:1], crc7_of({2'b01, idx, arg}), "command CRC7");
        check_value(card_frame[0], 1'b1, "end bit");
        read_reg(ADDR_INT_STATUS, rdata);
        check_value(rdata, {28'b0, exp_int}, "INT_STATUS");
        if (rtype && fault == 2'd0) begin
            read_reg(ADDR_RESPONSE, rdata);
            check_value(rdata, status, "RESPONSE");
        end
        read_reg(ADDR_PRESENT, rdata);
        check_value(rdata[0], 1'b0, "PRESENT busy after completion");

        // Mask everything that is set, unmask, then clear in two steps
        write_reg(ADDR_INT_ENABLE, {28'b0, ~exp_int});
        @(negedge clk);
        check_value(interrupt, 1'b0, "interrupt with set bits masked");
        write_reg(ADDR_INT_ENABLE, 32'hF);
        @(negedge clk);
        check_value(interrupt, |exp_int, "interrupt with all bits enabled");
        write_reg(ADDR_INT_STATUS, 32'h1 << INT_CMD_DONE);
        @(negedge clk);
        check_value(interrupt, |(exp_int & ~(4'h1 << INT_CMD_DONE)),
                    "interrupt after clearing the done bit");
        write_reg(ADDR_INT_STATUS, 32'hF);
        @(negedge clk);
        check_value(interrupt, 1'b0, "interrupt after clearing all bits");
        read_reg(ADDR_INT_STATUS, rdata);
        check_value(rdata, 32'h0, "INT_STATUS after clearing");
    endtask

    task automatic check_busy_drop();
        logic [31:0] rdata;
        int          frames_before;
        tag = "BUSY:";
        @(posedge clk);
        resp_en    <= 1'b1;
        resp_frame <= {2'b00, 6'h05, 32'h0000_0900,
                       crc7_of({2'b00, 6'h05, 32'h0000_0900}), 1'b1};
        frames_before = frame_cnt;
        write_reg(ADDR_ARGUMENT, 32'h0000_0001);
        write_reg(ADDR_COMMAND, 32'h0000_0105);
        read_reg(ADDR_PRESENT, rdata);
        check_value(rdata[0], 1'b1, "PRESENT during a command");
        write_reg(ADDR_COMMAND, 32'h0000_0106);
        wait_for_rise(1'b0, "the command interrupt");
        if (stalled) return;
        check_value(frame_cnt, frames_before + 1, "frames for two COMMAND writes");
        check_value(card_frame[45:40], 6'h05, "index of the accepted command");
        read_reg(ADDR_PRESENT, rdata);
        check_value(rdata[0], 1'b0, "PRESENT after the command");
        write_reg(ADDR_INT_STATUS, 32'hF);
    endtask

    task automatic check_soft_reset();
        logic [31:0] rdata;
        tag = "SOFT_RESET:";
        @(posedge clk);
        resp_en <= 1'b0;
        write_reg(ADDR_COMMAND, 32'h0000_0009);
        wait_for_rise(1'b1, "the host to drive CMD");
        if (stalled) return;
        write_reg(ADDR_SOFT_RESET, 32'h1);
        read_reg(ADDR_PRESENT, rdata);
        check_value(rdata[0], 1'b0, "PRESENT");
        check_value(host_oe, 1'b0, "CMD output enable");
        read_reg(ADDR_INT_STATUS, rdata);
        check_value(rdata, 32'h0, "INT_STATUS");
    endtask

    initial begin
        int          fd;
        int          rc;
        int          n;
        int          patterns;
        string       line;
        logic [31:0] rdata;
        logic [31:0] divisor, idx, arg, rtype, status, fault, exp_int;
        clk        = 1'b0;
        rst_n      = 1'b0;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        resp_en    = 1'b0;
        resp_frame = '1;
        errors     = 0;
        checks     = 0;
        patterns   = 0;
        stalled    = 1'b0;
        seed       = 32'h512a8e6f;
        tag        = "RESET:";
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value(host_oe, 1'b0, "CMD output enable");
        check_value(host_cmd, 1'b1, "CMD line");
        check_value(interrupt, 1'b0, "interrupt");
        read_reg(ADDR_INT_STATUS, rdata);
        check_value(rdata, 32'h0, "INT_STATUS");
        read_reg(ADDR_CLOCK_DIV, rdata);
        check_value(rdata, 32'h0, "divisor");
        write_reg(ADDR_INT_ENABLE, 32'hF);

        fd = $fopen("tests/sd_cmd_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the pattern file tests/sd_cmd_patterns.txt");
        end else begin
            while (!stalled && !$feof(fd)) begin
                rc = $fgets(line, fd);
                n  = 0;
                if (rc > 0 && line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                divisor, idx, arg, rtype, status, fault, exp_int);
                end
                if (n == 7) begin
                    patterns++;
                    run_command(divisor[7:0], idx[5:0], arg, rtype[0], status,
                                fault[1:0], exp_int[3:0]);
                end
            end
            $fclose(fd);
            if (patterns == 0) begin
                errors++;
                $display("No command patterns were found in the pattern file");
            end
        end
        if (!stalled) begin
            check_busy_drop();
        end
        if (!stalled) begin
            check_soft_reset();
        end

        $display("Commands from patterns: %0d, checks: %0d, errors: %0d",
                 patterns, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
source/sd_cmd_pkg.sv
source/sd_cmd_ifs.sv
source/sd_host_regs.sv
source/sd_clock_divider.sv
source/sd_cmd_master.sv
source/sd_cmd_serial_host.sv
source/sd_cmd_top.sv
tests/sd_card_model.sv
tests/tb_sd_cmd.sv

// File: tests/sd_cmd_patterns.txt
# divisor index argument resp_type card_status fault expected_int_status (all hex)
# fault: 0 none, 1 bad response CRC, 2 wrong response index, 3 no response
00 00 00000000 0 00000000 0 1
01 08 000001aa 1 000001aa 0 1
03 37 00000000 1 00000120 0 1
00 11 00001000 1 00000900 1 3
02 0d 12340000 1 00000900 2 5
05 02 00000000 1 00000000 3 9
00 03 00000000 1 aaaa0520 0 1
07 07 abcd0000 1 00000700 0 1
01 10 00000200 0 00000000 0 1
